// ==== hdl/radio_ctrl_defines.svh ====
// Settings bus register map and constant values of the radio control plane
`ifndef RADIO_CTRL_DEFINES_SVH
`define RADIO_CTRL_DEFINES_SVH

//////////////////////////////////////////////////
// Settings bus base addresses

`define SR_MISC          8'd0     // Misc control block, 7 slots
`define SR_TIME64        8'd10    // VITA time block, 3 slots

//////////////////////////////////////////////////
// Offsets inside the misc block

`define MISC_SER_OFS     8'd1     // SERDES control lines
`define MISC_ADC_OFS     8'd2     // ADC enables
`define MISC_LED_OFS     8'd3     // Software LED value
`define MISC_PHY_OFS     8'd4     // Ethernet PHY reset

// Slot 5 held the boot flag and stays unused
`define MISC_LEDSRC_OFS  8'd6     // LED source select

//////////////////////////////////////////////////
// Offsets inside the time block

`define TIME_HI_OFS      8'd0     // Upper word, staged only
`define TIME_LO_OFS      8'd1     // Lower word, triggers the load
`define TIME_MODE_OFS    8'd2     // Bit 0 set means load on next PPS

// Bits 4..1 driven by hardware after reset
`define LED_SRC_DEFAULT  8'h1E

// Bump when the control plane changes in an incompatible way
`define COMPAT_MAJOR     16'd8
`define COMPAT_MINOR     16'd2

`endif

// ==== hdl/radio_ctrl_pkg.sv ====
// Shared settings bus, VITA time and control line types of the radio control plane
package radio_ctrl_pkg;

   //////////////////////////////////////////////////
   // Settings bus

   typedef logic [7:0]  set_addr_t;    // Register address
   typedef logic [31:0] set_data_t;    // Write data, also one readback word

   //////////////////////////////////////////////////
   // Timekeeping

   // Full tick count, upper word first on readback
   typedef logic [63:0] vita_time_t;

   //////////////////////////////////////////////////
   // Control and status

   typedef logic [3:0]  ctrl_nib_t;    // SERDES or ADC control lines
   typedef logic [7:0]  led_vec_t;     // One bit per front panel LED

   // Selects one of the readback words
   typedef logic [3:0]  rb_sel_t;

endpackage

// ==== hdl/misc_ctrl_regs.sv ====
// Misc control registers with SERDES, ADC, PHY and LED settings plus the LED source mix
`timescale 1ns/100ps
`include "radio_ctrl_defines.svh"

module misc_ctrl_regs (
   input  logic                      dsp_clk,
   input  logic                      por_rst,
   input  logic                      set_stb_i,
   input  radio_ctrl_pkg::set_addr_t set_addr_i,
   input  radio_ctrl_pkg::set_data_t set_data_i,
   input  logic                      clk_status_i,
   input  logic                      serdes_link_up_i,
   input  logic                      run_rx_i,
   input  logic                      run_tx_i,
   output radio_ctrl_pkg::ctrl_nib_t ser_ctrl_o,
   output radio_ctrl_pkg::ctrl_nib_t adc_ctrl_o,
   output logic                      phy_resetn_o,
   output radio_ctrl_pkg::led_vec_t  leds_o,
   output radio_ctrl_pkg::led_vec_t  led_state_o
);
   import radio_ctrl_pkg::*;

   localparam set_addr_t SER_ADDR    = `SR_MISC + `MISC_SER_OFS;
   localparam set_addr_t ADC_ADDR    = `SR_MISC + `MISC_ADC_OFS;
   localparam set_addr_t LED_ADDR    = `SR_MISC + `MISC_LED_OFS;
   localparam set_addr_t PHY_ADDR    = `SR_MISC + `MISC_PHY_OFS;
   localparam set_addr_t LEDSRC_ADDR = `SR_MISC + `MISC_LEDSRC_OFS;

   ctrl_nib_t ser_q;      // enable, prbsen, loopen, rx_en
   ctrl_nib_t adc_q;      // oe_a, on_a, oe_b, on_b
   logic      phy_rst_q;
   led_vec_t  led_sw_q;
   led_vec_t  led_src_q;  // 1 picks hardware, 0 picks software
   led_vec_t  led_hw;
   led_vec_t  led_mix;

   //////////////////////////////////////////////////
   // Register writes

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         ser_q     <= '0;
         adc_q     <= '0;
         phy_rst_q <= 1'b0;
         led_sw_q  <= '0;
         led_src_q <= `LED_SRC_DEFAULT;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SER_ADDR:    ser_q     <= set_data_i[3:0];
            ADC_ADDR:    adc_q     <= set_data_i[3:0];
            LED_ADDR:    led_sw_q  <= set_data_i[7:0];
            PHY_ADDR:    phy_rst_q <= set_data_i[0];
            LEDSRC_ADDR: led_src_q <= set_data_i[7:0];
            default:     ;   // Not ours
         endcase
      end
   end

   assign ser_ctrl_o   = ser_q;
   assign adc_ctrl_o   = adc_q;
   assign phy_resetn_o = ~phy_rst_q;   // PHY reset pin is active low

   //////////////////////////////////////////////////
   // LED mixing

   // Status lines that may drive the LEDs directly
   assign led_hw = {3'b000,
                    run_tx_i,
                    run_rx_i,
                    clk_status_i,
                    serdes_link_up_i,
                    1'b0};

   // Per bit choice between hardware and software
   assign led_mix = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   assign leds_o      = led_mix;
   assign led_state_o = led_mix;   // Same value for the readback word

   // Hardware LEDs must come back as soon as reset ends
   a_led_src_default: assert property (
      @(posedge dsp_clk) por_rst |=> (led_src_q == `LED_SRC_DEFAULT)
   ) else $error("LED source not at its default after reset");

endmodule

// ==== hdl/vita_timekeeper.sv ====
// VITA 64-bit time counter with settings bus load, PPS synchronizer and PPS time latch
`timescale 1ns/100ps
`include "radio_ctrl_defines.svh"

module vita_timekeeper (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       set_stb_i,
   input  radio_ctrl_pkg::set_addr_t  set_addr_i,
   input  radio_ctrl_pkg::set_data_t  set_data_i,
   input  logic                       pps_i,
   output radio_ctrl_pkg::vita_time_t vita_time_o,
   output radio_ctrl_pkg::vita_time_t vita_time_pps_o,
   output logic                       pps_int_o
);
   import radio_ctrl_pkg::*;

   localparam set_addr_t HI_ADDR   = `SR_TIME64 + `TIME_HI_OFS;
   localparam set_addr_t LO_ADDR   = `SR_TIME64 + `TIME_LO_OFS;
   localparam set_addr_t MODE_ADDR = `SR_TIME64 + `TIME_MODE_OFS;

   set_data_t  hi_stage;
   set_data_t  lo_stage;     // Kept for a PPS armed load
   logic       mode_pps;     // Load waits for the next PPS
   logic       load_armed;
   vita_time_t time_q;
   vita_time_t time_pps_q;
   logic       pps_meta;
   logic       pps_sync;
   logic       pps_prev;
   logic       pps_rise;
   logic       pps_int_q;
   logic       hi_wr;
   logic       lo_wr;
   logic       mode_wr;
   logic       load_imm;
   logic       load_pps;

   assign hi_wr   = set_stb_i && (set_addr_i == HI_ADDR);
   assign lo_wr   = set_stb_i && (set_addr_i == LO_ADDR);
   assign mode_wr = set_stb_i && (set_addr_i == MODE_ADDR);

   //////////////////////////////////////////////////
   // PPS input

   // Two flops against metastability, one more for the edge
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_prev <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_prev <= pps_sync;
      end
   end

   assign pps_rise = pps_sync & ~pps_prev;   // True for one cycle per pulse

   //////////////////////////////////////////////////
   // Load staging

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         hi_stage   <= '0;
         lo_stage   <= '0;
         mode_pps   <= 1'b0;
         load_armed <= 1'b0;
      end else begin
         if (hi_wr)
            hi_stage <= set_data_i;
         if (lo_wr)
            lo_stage <= set_data_i;
         if (mode_wr)
            mode_pps <= set_data_i[0];
         // A new arm wins over a PPS in the same cycle
         if (lo_wr && mode_pps)
            load_armed <= 1'b1;
         else if (pps_rise)
            load_armed <= 1'b0;
      end
   end

   assign load_imm = lo_wr && !mode_pps;
   assign load_pps = pps_rise && load_armed;

   //////////////////////////////////////////////////
   // Tick counter and PPS latch

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         time_q <= '0;
      else if (load_imm)
         time_q <= {hi_stage, set_data_i};
      else if (load_pps)
         time_q <= {hi_stage, lo_stage};
      else
         time_q <= time_q + 64'd1;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_pps_q <= '0;
         pps_int_q  <= 1'b0;
      end else begin
         pps_int_q <= pps_rise;
         if (pps_rise)
            time_pps_q <= time_q;   // Time before the capture edge
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = time_pps_q;
   assign pps_int_o       = pps_int_q;

   a_pps_int_single: assert property (
      @(posedge dsp_clk) disable iff (por_rst) pps_int_q |=> !pps_int_q
   ) else $error("PPS interrupt held for more than one cycle");

   // Free running count between loads
   a_time_step: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
         !(load_imm || load_pps) |=> (time_q == $past(time_q) + 64'd1)
   ) else $error("Time counter skipped without a load");

endmodule

// ==== hdl/status_readback.sv ====
// Registered readback mux of compatibility, time and status words
`timescale 1ns/100ps
`include "radio_ctrl_defines.svh"

module status_readback (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  radio_ctrl_pkg::rb_sel_t    rb_sel_i,
   input  radio_ctrl_pkg::vita_time_t vita_time_i,
   input  radio_ctrl_pkg::vita_time_t vita_time_pps_i,
   input  radio_ctrl_pkg::led_vec_t   led_state_i,
   input  logic                       button_i,
   input  logic                       clk_status_i,
   input  logic                       serdes_link_up_i,
   output radio_ctrl_pkg::set_data_t  rb_data_o
);
   import radio_ctrl_pkg::*;

   localparam rb_sel_t RB_COMPAT  = 4'd0;
   localparam rb_sel_t RB_TIME_HI = 4'd1;
   localparam rb_sel_t RB_TIME_LO = 4'd2;
   localparam rb_sel_t RB_STATUS  = 4'd3;
   localparam rb_sel_t RB_PPS_HI  = 4'd4;
   localparam rb_sel_t RB_PPS_LO  = 4'd5;
   localparam rb_sel_t RB_LEDS    = 4'd6;

   set_data_t status_word;
   set_data_t rb_q;

   // Button 13, clock status 11, link up 10
   assign status_word = {18'd0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'd0};

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_q <= '0;
      end else begin
         case (rb_sel_i)
            RB_COMPAT:  rb_q <= {`COMPAT_MAJOR, `COMPAT_MINOR};
            RB_TIME_HI: rb_q <= vita_time_i[63:32];
            RB_TIME_LO: rb_q <= vita_time_i[31:0];
            RB_STATUS:  rb_q <= status_word;
            RB_PPS_HI:  rb_q <= vita_time_pps_i[63:32];
            RB_PPS_LO:  rb_q <= vita_time_pps_i[31:0];
            RB_LEDS:    rb_q <= {24'd0, led_state_i};
            default:    rb_q <= '0;
         endcase
      end
   end

   assign rb_data_o = rb_q;

   a_rb_sel_known: assert property (
      @(posedge dsp_clk) disable iff (por_rst) !$isunknown(rb_sel_i)
   ) else $error("Readback select has unknown bits");

endmodule

// ==== hdl/radio_ctrl_top.sv ====
// Radio DSP clock control plane with misc registers, VITA time and status readback
`timescale 1ns/100ps

module radio_ctrl_top (
   input  logic                      dsp_clk,
   input  logic                      por_rst,
   input  logic                      set_stb_i,
   input  radio_ctrl_pkg::set_addr_t set_addr_i,
   input  radio_ctrl_pkg::set_data_t set_data_i,
   input  logic                      pps_i,
   input  logic                      button_i,
   input  logic                      clk_status_i,
   input  logic                      serdes_link_up_i,
   input  logic                      run_rx_i,
   input  logic                      run_tx_i,
   input  radio_ctrl_pkg::rb_sel_t   rb_sel_i,
   output radio_ctrl_pkg::set_data_t rb_data_o,
   output radio_ctrl_pkg::led_vec_t  leds_o,
   output radio_ctrl_pkg::ctrl_nib_t ser_ctrl_o,
   output radio_ctrl_pkg::ctrl_nib_t adc_ctrl_o,
   output logic                      phy_resetn_o,
   output logic                      pps_int_o
);
   import radio_ctrl_pkg::*;

   vita_time_t vita_time;
   vita_time_t vita_time_pps;   // Time at the last PPS
   led_vec_t   led_state;

   //////////////////////////////////////////////////
   // Settings bus clients

   misc_ctrl_regs u_misc_ctrl_regs (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .set_stb_i        (set_stb_i),
      .set_addr_i       (set_addr_i),
      .set_data_i       (set_data_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .ser_ctrl_o       (ser_ctrl_o),
      .adc_ctrl_o       (adc_ctrl_o),
      .phy_resetn_o     (phy_resetn_o),
      .leds_o           (leds_o),
      .led_state_o      (led_state)
   );

   vita_timekeeper u_vita_timekeeper (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_stb_i       (set_stb_i),
      .set_addr_i      (set_addr_i),
      .set_data_i      (set_data_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int_o)
   );

   //////////////////////////////////////////////////
   // Readback

   status_readback u_status_readback (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .rb_sel_i         (rb_sel_i),
      .vita_time_i      (vita_time),
      .vita_time_pps_i  (vita_time_pps),
      .led_state_i      (led_state),
      .button_i         (button_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .rb_data_o        (rb_data_o)
   );

endmodule

// ==== tb/tb_radio_ctrl.sv ====
// Self-checking testbench of the radio control plane driven by a patterns file
`timescale 1ns/100ps
`include "radio_ctrl_defines.svh"

module tb_radio_ctrl;
   import radio_ctrl_pkg::*;

   localparam int        PPS_TIMEOUT = 40;   // Cycles allowed for the PPS interrupt
   localparam set_addr_t SER_ADDR    = `SR_MISC + `MISC_SER_OFS;
   localparam set_addr_t ADC_ADDR    = `SR_MISC + `MISC_ADC_OFS;
   localparam set_addr_t PHY_ADDR    = `SR_MISC + `MISC_PHY_OFS;
   localparam set_addr_t HI_ADDR     = `SR_TIME64 + `TIME_HI_OFS;
   localparam set_addr_t LO_ADDR     = `SR_TIME64 + `TIME_LO_OFS;
   localparam set_addr_t MODE_ADDR   = `SR_TIME64 + `TIME_MODE_OFS;

   logic        dsp_clk = 1'b0;
   logic        por_rst;
   logic        set_stb_i;
   set_addr_t   set_addr_i;
   set_data_t   set_data_i;
   logic        pps_i;
   logic        button_i;
   logic        clk_status_i;
   logic        serdes_link_up_i;
   logic        run_rx_i;
   logic        run_tx_i;
   rb_sel_t     rb_sel_i;
   set_data_t   rb_data_o;
   led_vec_t    leds_o;
   ctrl_nib_t   ser_ctrl_o;
   ctrl_nib_t   adc_ctrl_o;
   logic        phy_resetn_o;
   logic        pps_int_o;

   int unsigned edge_cnt = 0;   // Rising edges seen so far
   int unsigned n_checks = 0;
   int unsigned value_errs = 0;
   int unsigned other_errs = 0;
   ctrl_nib_t   exp_ser;
   ctrl_nib_t   exp_adc;
   logic        exp_phy_n;
   vita_time_t  ref_time;       // Time value right after edge ref_edge
   int unsigned ref_edge;

   radio_ctrl_top DUT (.*);

   always #4 dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) edge_cnt <= edge_cnt + 1;

   //////////////////////////////////////////////////
   // Checks and reference model

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      n_checks++;
      if (got !== exp) begin
         value_errs++;
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_ctrl();
      check_value("ser_ctrl_o", 64'(ser_ctrl_o), 64'(exp_ser));
      check_value("adc_ctrl_o", 64'(adc_ctrl_o), 64'(exp_adc));
      check_value("phy_resetn_o", 64'(phy_resetn_o), 64'(exp_phy_n));
   endtask

   // Counter value after edge e since the last load
   function automatic vita_time_t time_after(input int unsigned e);
      return ref_time + 64'(e - ref_edge);
   endfunction

   //////////////////////////////////////////////////
   // Bus and pin drivers

   task automatic bus_write(input set_addr_t addr, input set_data_t data);
      @(negedge dsp_clk);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge dsp_clk);
      set_stb_i  = 1'b0;
      case (addr)
         SER_ADDR: exp_ser = data[3:0];
         ADC_ADDR: exp_adc = data[3:0];
         PHY_ADDR: exp_phy_n = ~data[0];   // Active low pin
         default:  ;
      endcase
      check_ctrl();
   endtask

   task automatic apply_status(input logic [4:0] bits);
      @(negedge dsp_clk);
      button_i         = bits[4];
      run_tx_i         = bits[3];
      run_rx_i         = bits[2];
      clk_status_i     = bits[1];
      serdes_link_up_i = bits[0];
   endtask

   // Word is registered on the edge between the two falling edges
   task automatic read_rb(input rb_sel_t sel, output set_data_t data, output int unsigned e);
      @(negedge dsp_clk);
      rb_sel_i = sel;
      @(negedge dsp_clk);
      data = rb_data_o;
      e    = edge_cnt;
   endtask

   task automatic check_time_words();
      set_data_t   word;
      int unsigned e;
      vita_time_t  exp_t;
      read_rb(4'd1, word, e);
      exp_t = time_after(e - 1);
      check_value("rb_data_o time hi", 64'(word), 64'(exp_t[63:32]));
      read_rb(4'd2, word, e);
      exp_t = time_after(e - 1);
      check_value("rb_data_o time lo", 64'(word), 64'(exp_t[31:0]));
   endtask

   task automatic check_pps_words(input vita_time_t exp_t);
      set_data_t   word;
      int unsigned e;
      read_rb(4'd4, word, e);
      check_value("rb_data_o PPS hi", 64'(word), 64'(exp_t[63:32]));
      read_rb(4'd5, word, e);
      check_value("rb_data_o PPS lo", 64'(word), 64'(exp_t[31:0]));
   endtask

   // Raises PPS and returns the capture edge predicted by the synchronizer depth
   task automatic pulse_pps(output int unsigned cap_edge);
      int unsigned n;
      bit          seen;
      repeat (1 + $urandom_range(12)) @(negedge dsp_clk);
      pps_i    = 1'b1;
      cap_edge = edge_cnt + 3;   // Third edge that samples PPS high
      seen     = 1'b0;
      n        = 0;
      while (!seen && n < PPS_TIMEOUT) begin
         @(negedge dsp_clk);
         n++;
         if (pps_int_o)
            seen = 1'b1;
      end
      if (!seen) begin
         other_errs++;
         $display("PPS interrupt did not arrive within %0d cycles", PPS_TIMEOUT);
      end else begin
         check_value("pps_int_o capture edge", 64'(edge_cnt), 64'(cap_edge));
         @(negedge dsp_clk);
         check_value("pps_int_o second cycle", 64'(pps_int_o), 64'd0);
      end
      pps_i = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // Test sequences

   task automatic run_patterns();
      int          fd;
      int          n;
      string       line;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      set_data_t   word;
      int unsigned e;
      fd = $fopen("tb/radio_ctrl_patterns.txt", "r");
      if (fd == 0) begin
         other_errs++;
         $display("Could not open the pattern file");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line[0] != "#") begin
            a = '0;
            b = '0;
            c = '0;
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
            case (line[0])
               "W": bus_write(a[7:0], b);
               "S": apply_status(a[4:0]);
               "C": begin
                  read_rb(a[3:0], word, e);
                  check_value("rb_data_o", 64'(word), 64'(b));
                  check_value("leds_o", 64'(leds_o), 64'(c[7:0]));
               end
               default: begin
                  other_errs++;
                  $display("Unknown command in the pattern file");
               end
            endcase
         end
      end
      $fclose(fd);
   endtask

   task automatic time_tests();
      set_data_t   hi;
      set_data_t   lo;
      int unsigned cap;
      vita_time_t  exp_t;
      hi = $urandom();
      lo = $urandom();
      bus_write(HI_ADDR, hi);
      bus_write(LO_ADDR, lo);   // Mode 0 loads at once
      ref_time = {hi, lo};
      ref_edge = edge_cnt;
      repeat ($urandom_range(5)) @(negedge dsp_clk);
      check_time_words();
      pulse_pps(cap);
      check_pps_words(time_after(cap - 1));
      check_time_words();
      // Load armed for the next PPS
      bus_write(MODE_ADDR, 32'd1);
      hi = $urandom();
      lo = $urandom();
      bus_write(HI_ADDR, hi);
      bus_write(LO_ADDR, lo);
      check_time_words();   // Still free running
      pulse_pps(cap);
      exp_t    = time_after(cap - 1);
      ref_time = {hi, lo};
      ref_edge = cap;
      check_pps_words(exp_t);
      check_time_words();
      bus_write(MODE_ADDR, 32'd0);
   endtask

   initial begin
      void'($urandom(32'h8e2d5df6));
      por_rst          = 1'b1;
      set_stb_i        = 1'b0;
      set_addr_i       = '0;
      set_data_i       = '0;
      pps_i            = 1'b0;
      button_i         = 1'b0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      run_rx_i         = 1'b0;
      run_tx_i         = 1'b0;
      rb_sel_i         = '0;
      exp_ser          = '0;
      exp_adc          = '0;
      exp_phy_n        = 1'b1;
      ref_time         = '0;
      ref_edge         = 0;
      repeat (8) @(negedge dsp_clk);
      por_rst = 1'b0;
      check_value("rb_data_o", 64'(rb_data_o), 64'd0);
      check_ctrl();
      run_patterns();
      time_tests();
      $display("Checks: %0d, value errors: %0d, other errors: %0d",
               n_checks, value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== tb/radio_ctrl_patterns.txt ====
# W <addr> <data> bus write, S <status> input levels, C <rb_sel> <rb_data> <leds> check
# Status bits {button, run_tx, run_rx, clk_status, link_up}; all values hex
S 03
C 0 00080002 06
C 3 00000c00 06
W 01 0000000b
W 02 00000005
W 04 00000001
W 05 ffffffff
W 07 12345678
W 0d 0000ffff
W 04 00000000
W 03 000000a5
C 6 000000a7 a7
S 0d
C 6 000000bb bb
C 3 00000400 bb
W 06 0000000f
C 6 000000aa aa
S 16
C 6 000000ac ac
C 3 00002800 ac
W 03 0000003c
C 6 0000003c 3c
W 06 000000f0
C 6 0000000c 0c
S 08
C 6 0000001c 1c
W 06 0000001e
C 6 00000030 30
C 7 00000000 30
C 0 00080002 30

// ==== compile.f ====
+incdir+hdl
hdl/radio_ctrl_pkg.sv
hdl/misc_ctrl_regs.sv
hdl/vita_timekeeper.sv
hdl/status_readback.sv
hdl/radio_ctrl_top.sv
tb/tb_radio_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

LOG=sim.log

verilator --binary --timing --assert --Mdir obj_dir \
   --top-module tb_radio_ctrl -f compile.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_radio_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   exit 1
fi
exit 0
